/* common/dmem_defines.svh */
// ######################################
// data memory sizing
// ######################################

`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// word index width, 256 words
`define DMEM_WORD_ADDR_BITS 8

`define DMEM_LANES 4

`endif

/* common/rv32i_types_pkg.sv */
// ######################################
// rv32i types
// word and register index types shared
// by the pipeline, plus the load/store
// access type encoding (funct3)
// ######################################

package rv32i_types_pkg;

  // data and address word
  typedef logic [31:0] word_t;

  // destination register index
  typedef logic [4:0] regbits_t;

  // access type, funct3 encoding
  // stores only use LB, LH and LW to give their width
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

endpackage

/* common/dmem_pkg.sv */
// ######################################
// data memory types
// byte enables and the two views of a
// data word used on the load path
// ######################################

`include "dmem_defines.svh"

package dmem_pkg;

  // one enable per byte lane, bit 0 is the lowest address
  typedef logic [`DMEM_LANES-1:0] byte_en_t;

  // read word seen as lane bytes or as halfwords
  typedef union packed {
    logic [`DMEM_LANES-1:0][7:0] byte_lane;
    logic [1:0][15:0]            half;
  } dmem_word_u;

endpackage

/* memory_stage/pipe5_memory_stage.sv */
// ######################################
// pipe5 memory stage
// decodes byte enables, flags misaligned
// loads and stores, replicates store data
// across the lanes and carries the load
// context one cycle toward the extender
// ######################################

`timescale 1ns/1ns

`include "dmem_defines.svh"

module pipe5_memory_stage
  import rv32i_types_pkg::*;
  import dmem_pkg::*;
(
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            halt,
  input  logic                            dren,
  input  logic                            dwen,
  input  word_t                           memory_addr,
  input  word_t                           store_wdata,
  input  load_t                           load_type,
  input  regbits_t                        reg_rd,
  output byte_en_t                        lane_we,
  output logic                            lane_re,
  output logic [`DMEM_WORD_ADDR_BITS-1:0] word_addr,
  output word_t                           lane_wdata,
  output logic                            ld_valid,
  output load_t                           ld_type,
  output byte_en_t                        ld_byte_en,
  output regbits_t                        ld_rd,
  output logic                            mal_l,
  output logic                            mal_s,
  output word_t                           badaddr_d
);

  byte_en_t byte_en;
  logic     mal_addr;

  // enables and alignment from access width and low address bits
  always_comb begin
    byte_en  = '0;
    mal_addr = 1'b0;
    case (load_type)
      LW: begin
        byte_en  = 4'hf;
        mal_addr = (memory_addr[1:0] != 2'b00);
      end
      LH, LHU: begin
        byte_en  = memory_addr[1] ? 4'hc : 4'h3;
        mal_addr = memory_addr[0];  // odd halfword address
      end
      LB, LBU: begin
        byte_en = byte_en_t'(1) << memory_addr[1:0];
      end
      default: begin
        byte_en  = '0;
        mal_addr = 1'b0;
      end
    endcase
  end

  // store data copied onto every lane it could land in
  always_comb begin
    case (load_type)
      LB, LBU: lane_wdata = {4{store_wdata[7:0]}};
      LH, LHU: lane_wdata = {2{store_wdata[15:0]}};
      default: lane_wdata = store_wdata;
    endcase
  end

  // a misaligned access never reaches the lanes
  assign lane_re   = dren & ~mal_addr;
  assign lane_we   = (dwen & ~mal_addr) ? byte_en : '0;
  assign word_addr = memory_addr[`DMEM_WORD_ADDR_BITS+1:2];

  // load valid, lines up with the lanes' registered rdata
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      ld_valid <= 1'b0;
    end else if (halt) begin
      ld_valid <= 1'b0;
    end else begin
      ld_valid <= lane_re;
    end
  end

  // context payload, only meaningful while ld_valid is set
  always_ff @(posedge CLK) begin
    if (lane_re) begin
      ld_type    <= load_type;
      ld_byte_en <= byte_en;
      ld_rd      <= reg_rd;
    end
  end

  // fault strobes last one cycle, address held alongside
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      mal_l     <= 1'b0;
      mal_s     <= 1'b0;
      badaddr_d <= '0;
    end else if (halt) begin
      mal_l <= 1'b0;
      mal_s <= 1'b0;
    end else begin
      mal_l <= dren & mal_addr;
      mal_s <= dwen & mal_addr;
      if (mal_addr & (dren | dwen)) begin
        badaddr_d <= memory_addr;
      end
    end
  end

endmodule

/* dmem/dmem_lane.sv */
// ######################################
// data memory lane
// one byte wide synchronous RAM with a
// registered read port
// ######################################

`timescale 1ns/1ns

`include "dmem_defines.svh"

module dmem_lane (
  input  logic                            CLK,
  input  logic                            nRST,
  input  logic                            we,
  input  logic                            re,
  input  logic [`DMEM_WORD_ADDR_BITS-1:0] word_addr,
  input  logic [7:0]                      wdata,
  output logic [7:0]                      rdata
);

  logic [7:0] mem [2**`DMEM_WORD_ADDR_BITS];

  // write port
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[word_addr] <= wdata;
    end
  end

  // read data captured on the strobe edge
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[word_addr];
    end
  end

endmodule

/* src/dmem_extender.sv */
// ######################################
// load extender
// picks the loaded byte or halfword out
// of the read word, extends it by type
// and registers the writeback result
// ######################################

`timescale 1ns/1ns

module dmem_extender
  import rv32i_types_pkg::*;
  import dmem_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     halt,
  input  logic     ld_valid,
  input  load_t    ld_type,
  input  byte_en_t ld_byte_en,
  input  regbits_t ld_rd,
  input  word_t    lane_rdata,
  output logic     wb_valid,
  output regbits_t wb_rd,
  output word_t    wb_data
);

  dmem_word_u rd_word;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  word_t       ext_data;

  assign rd_word = lane_rdata;

  // one-hot enable picks the byte lane
  always_comb begin
    case (ld_byte_en)
      4'b0010: sel_byte = rd_word.byte_lane[1];
      4'b0100: sel_byte = rd_word.byte_lane[2];
      4'b1000: sel_byte = rd_word.byte_lane[3];
      default: sel_byte = rd_word.byte_lane[0];
    endcase
  end

  assign sel_half = rd_word.half[ld_byte_en[2]];  // 4'hc selects the upper half

  always_comb begin
    case (ld_type)
      LB:      ext_data = {{24{sel_byte[7]}}, sel_byte};
      LBU:     ext_data = {24'h0, sel_byte};
      LH:      ext_data = {{16{sel_half[15]}}, sel_half};
      LHU:     ext_data = {16'h0, sel_half};
      default: ext_data = word_t'(rd_word);  // LW passes through
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else if (halt) begin
      wb_valid <= 1'b0;
      wb_rd    <= '0;
      wb_data  <= '0;
    end else begin
      wb_valid <= ld_valid;
      wb_rd    <= ld_rd;
      wb_data  <= ext_data;
    end
  end

endmodule

/* src/mem_subsystem_top.sv */
// ######################################
// memory subsystem
// memory stage, byte lane data memory
// and load extender of the pipeline
// ######################################

`timescale 1ns/1ns

`include "dmem_defines.svh"

module mem_subsystem_top
  import rv32i_types_pkg::*;
  import dmem_pkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     halt,
  input  logic     dren,
  input  logic     dwen,
  input  word_t    memory_addr,
  input  word_t    store_wdata,
  input  load_t    load_type,
  input  regbits_t reg_rd,
  output logic     wb_valid,
  output regbits_t wb_rd,
  output word_t    wb_data,
  output logic     mal_l,
  output logic     mal_s,
  output word_t    badaddr_d
);

  byte_en_t                        lane_we;
  logic                            lane_re;
  logic [`DMEM_WORD_ADDR_BITS-1:0] word_addr;
  word_t                           lane_wdata;
  word_t                           lane_rdata;  // joined lane bytes
  logic                            ld_valid;
  load_t                           ld_type;
  byte_en_t                        ld_byte_en;
  regbits_t                        ld_rd;

  pipe5_memory_stage u_mem_stage (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .dren        (dren),
    .dwen        (dwen),
    .memory_addr (memory_addr),
    .store_wdata (store_wdata),
    .load_type   (load_type),
    .reg_rd      (reg_rd),
    .lane_we     (lane_we),
    .lane_re     (lane_re),
    .word_addr   (word_addr),
    .lane_wdata  (lane_wdata),
    .ld_valid    (ld_valid),
    .ld_type     (ld_type),
    .ld_byte_en  (ld_byte_en),
    .ld_rd       (ld_rd),
    .mal_l       (mal_l),
    .mal_s       (mal_s),
    .badaddr_d   (badaddr_d)
  );

  // lane n holds address byte n of each word
  for (genvar i = 0; i < `DMEM_LANES; i++) begin : g_lane
    dmem_lane u_lane (
      .CLK       (CLK),
      .nRST      (nRST),
      .we        (lane_we[i]),
      .re        (lane_re),
      .word_addr (word_addr),
      .wdata     (lane_wdata[8*i +: 8]),
      .rdata     (lane_rdata[8*i +: 8])
    );
  end

  dmem_extender u_extender (
    .CLK        (CLK),
    .nRST       (nRST),
    .halt       (halt),
    .ld_valid   (ld_valid),
    .ld_type    (ld_type),
    .ld_byte_en (ld_byte_en),
    .ld_rd      (ld_rd),
    .lane_rdata (lane_rdata),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

/* sim/tb_mem_subsystem.sv */
// ######################################
// memory subsystem testbench
// file driven loads, stores and halts,
// writebacks checked against a queue of
// expected results, fault strobes checked
// every cycle
// ######################################

`timescale 1ns/1ns

module tb_mem_subsystem
  import rv32i_types_pkg::*;
();

  localparam int DRAIN_LIMIT = 16;  // idle cycles allowed for writebacks to land

  logic     CLK;
  logic     nRST;
  logic     halt;
  logic     dren;
  logic     dwen;
  word_t    memory_addr;
  word_t    store_wdata;
  load_t    load_type;
  regbits_t reg_rd;
  logic     wb_valid;
  regbits_t wb_rd;
  word_t    wb_data;
  logic     mal_l;
  logic     mal_s;
  word_t    badaddr_d;

  int cycle;
  int checks;
  int errors;
  int tests_run;
  int tests_failed;
  int test_first_error;
  logic aborted;  // set when writebacks fail to drain

  // expected writebacks, one entry per load still in flight
  int       due_q[$];
  regbits_t rd_q[$];
  word_t    val_q[$];

  logic  exp_mal_l;
  logic  exp_mal_s;
  word_t exp_badaddr;

  mem_subsystem_top u_dut (
    .CLK         (CLK),
    .nRST        (nRST),
    .halt        (halt),
    .dren        (dren),
    .dwen        (dwen),
    .memory_addr (memory_addr),
    .store_wdata (store_wdata),
    .load_type   (load_type),
    .reg_rd      (reg_rd),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .mal_l       (mal_l),
    .mal_s       (mal_s),
    .badaddr_d   (badaddr_d)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_condition(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  // outputs settle after the rising edge, so look at them on the falling one
  task automatic sample_outputs();
    int       due;
    regbits_t rd;
    word_t    val;
    check_value("mal_l", word_t'(mal_l), word_t'(exp_mal_l));
    check_value("mal_s", word_t'(mal_s), word_t'(exp_mal_s));
    if (exp_mal_l || exp_mal_s) begin
      check_value("badaddr_d", badaddr_d, exp_badaddr);
    end
    if (wb_valid === 1'b1) begin
      check_condition(due_q.size() != 0,
                      $sformatf("unexpected writeback in cycle %0d", cycle));
      if (due_q.size() != 0) begin
        due = due_q.pop_front();
        rd  = rd_q.pop_front();
        val = val_q.pop_front();
        check_condition(due == cycle,
                        $sformatf("writeback to x%0d came in cycle %0d instead of cycle %0d",
                                  rd, cycle, due));
        check_value("wb_rd", word_t'(wb_rd), word_t'(rd));
        check_value("wb_data", wb_data, val);
      end
    end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
      check_condition(1'b0, $sformatf("wb_valid never arrived for load to x%0d", rd_q[0]));
      void'(due_q.pop_front());
      void'(rd_q.pop_front());
      void'(val_q.pop_front());
    end else begin
      check_value("wb_valid", word_t'(wb_valid), '0);
    end
  endtask

  // one clock of stimulus, checks come first
  task automatic run_cycle(input logic rd_en, input logic wr_en, input logic hlt,
                           input logic [2:0] lt, input word_t addr, input word_t wd,
                           input regbits_t rd);
    @(negedge CLK);
    cycle++;
    sample_outputs();
    dren        = rd_en;
    dwen        = wr_en;
    halt        = hlt;
    load_type   = load_t'(lt);
    memory_addr = addr;
    store_wdata = wd;
    reg_rd      = rd;
  endtask

  task automatic expect_fault(input logic l, input logic s, input word_t addr);
    exp_mal_l   = l;
    exp_mal_s   = s;
    exp_badaddr = addr;
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, 1'b0, 1'b0, 3'h2, '0, '0, '0);
    expect_fault(1'b0, 1'b0, '0);
  endtask

  task automatic apply_line(input logic [63:0] op, input logic [2:0] lt, input word_t addr,
                            input word_t wd, input regbits_t rd, input word_t exp_val,
                            input logic mal);
    if (op == "load") begin
      run_cycle(1'b1, 1'b0, 1'b0, lt, addr, wd, rd);
      expect_fault(mal, 1'b0, addr);
      if (!mal) begin
        due_q.push_back(cycle + 2);  // strobe edge, extender edge, then visible
        rd_q.push_back(rd);
        val_q.push_back(exp_val);
      end
    end else if (op == "store") begin
      run_cycle(1'b0, 1'b1, 1'b0, lt, addr, wd, rd);
      expect_fault(1'b0, mal, addr);
    end else if (op == "halt") begin
      run_cycle(1'b0, 1'b0, 1'b1, lt, addr, wd, rd);
      expect_fault(1'b0, 1'b0, addr);
      // anything not yet visible is flushed
      while (due_q.size() != 0 && due_q[$] > cycle) begin
        void'(due_q.pop_back());
        void'(rd_q.pop_back());
        void'(val_q.pop_back());
      end
    end else if (op == "idle") begin
      idle_cycle();
    end else begin
      check_condition(1'b0, $sformatf("unknown op %0s in stimulus file", op));
    end
  endtask

  task automatic finish_test(input int tnum);
    int waited;
    waited = 0;
    while (due_q.size() != 0 && waited < DRAIN_LIMIT) begin
      idle_cycle();
      waited++;
    end
    if (due_q.size() != 0) begin
      $display("test %0d: timed out waiting for writebacks to drain", tnum);
      tests_run++;
      tests_failed++;
      aborted = 1'b1;
    end else begin
      idle_cycle();  // picks up a fault strobe from the last request
      tests_run++;
      if (errors == test_first_error) begin
        $display("test %0d: pass", tnum);
      end else begin
        tests_failed++;
        $display("test %0d: FAIL with %0d errors", tnum, errors - test_first_error);
      end
      test_first_error = errors;
    end
  endtask

  task automatic run_file(input int fd);
    string       line;
    int          n;
    int          tnum;
    int          cur_test;
    int          mal;
    logic [63:0] op;
    logic [2:0]  lt;
    word_t       addr;
    word_t       wd;
    word_t       exp_val;
    regbits_t    rd;
    cur_test = -1;
    while (!$feof(fd) && !aborted) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%d %s %h %h %h %h %h %d", tnum, op, lt, addr, wd, rd, exp_val, mal);
        if (n != 8) begin
          check_condition(1'b0, $sformatf("malformed stimulus line: %0s", line));
        end else begin
          if (cur_test >= 0 && tnum != cur_test) begin
            finish_test(cur_test);
          end
          cur_test = tnum;
          if (!aborted) begin
            apply_line(op, lt, addr, wd, rd, exp_val, mal != 0);
          end
        end
      end
    end
    if (cur_test >= 0 && !aborted) begin
      finish_test(cur_test);
    end
  endtask

  initial begin
    int fd;
    nRST             = 1'b0;
    halt             = 1'b0;
    dren             = 1'b0;
    dwen             = 1'b0;
    memory_addr      = '0;
    store_wdata      = '0;
    load_type        = LW;
    reg_rd           = '0;
    cycle            = 0;
    checks           = 0;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    test_first_error = 0;
    aborted          = 1'b0;
    expect_fault(1'b0, 1'b0, '0);
    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    fd = $fopen("sim/mem_stage_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/mem_stage_stimulus.txt");
      $display("Test failures found");
      $finish;
    end else begin
      run_file(fd);
      $fclose(fd);
      $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, checks, errors);
      if (errors == 0 && !aborted) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

/* sim/mem_stage_stimulus.txt */
# test op load_type addr store_data rd expected_wb mal   (test and mal decimal, rest hex)
# load_type 0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU; a load right before a halt is flushed
1 idle  2 00000000 00000000 00 00000000 0
1 idle  2 00000000 00000000 00 00000000 0
1 idle  2 00000000 00000000 00 00000000 0
2 store 2 00000010 deadbeef 00 00000000 0
2 store 2 00000014 12345678 00 00000000 0
2 store 2 000003fc a5a5c3c3 00 00000000 0
2 load  2 00000010 00000000 05 deadbeef 0
2 load  2 00000014 00000000 06 12345678 0
2 load  2 000003fc 00000000 1f a5a5c3c3 0
2 store 2 00000018 0f0f0f0f 00 00000000 0
2 load  2 00000018 00000000 07 0f0f0f0f 0
3 store 2 00000020 11223344 00 00000000 0
3 store 0 00000021 ffffffab 00 00000000 0
3 store 1 00000022 555580f7 00 00000000 0
3 store 0 00000020 0000009c 00 00000000 0
3 load  2 00000020 00000000 0a 80f7ab9c 0
3 load  0 00000020 00000000 0b ffffff9c 0
3 load  4 00000020 00000000 0c 0000009c 0
3 load  0 00000021 00000000 0d ffffffab 0
3 load  4 00000021 00000000 0e 000000ab 0
3 load  0 00000022 00000000 0f fffffff7 0
3 load  0 00000023 00000000 10 ffffff80 0
3 load  4 00000023 00000000 11 00000080 0
3 load  1 00000020 00000000 12 ffffab9c 0
3 load  5 00000020 00000000 13 0000ab9c 0
3 load  1 00000022 00000000 14 ffff80f7 0
3 load  5 00000022 00000000 15 000080f7 0
3 store 2 00000024 7f01327f 00 00000000 0
3 load  0 00000024 00000000 16 0000007f 0
3 load  1 00000026 00000000 17 00007f01 0
3 load  0 00000025 00000000 18 00000032 0
4 store 2 00000030 cafef00d 00 00000000 0
4 store 2 00000031 11111111 00 00000000 1
4 store 1 00000033 00002222 00 00000000 1
4 store 2 00000032 33333333 00 00000000 1
4 load  2 00000032 00000000 19 00000000 1
4 load  1 00000031 00000000 1a 00000000 1
4 load  5 00000037 00000000 1b 00000000 1
4 load  2 00000030 00000000 1c cafef00d 0
5 store 2 00000040 0badf00d 00 00000000 0
5 store 2 00000044 600dcafe 00 00000000 0
5 store 2 00000048 13579bdf 00 00000000 0
5 load  2 00000040 00000000 01 0badf00d 0
5 load  2 00000044 00000000 02 600dcafe 0
5 load  2 00000048 00000000 03 13579bdf 0
5 load  2 00000040 00000000 04 0badf00d 0
5 load  2 00000044 00000000 08 600dcafe 0
5 halt  2 00000000 00000000 00 00000000 0
5 load  2 00000048 00000000 09 13579bdf 0
5 load  2 00000048 00000000 1d 13579bdf 0
5 halt  2 00000000 00000000 00 00000000 0
5 idle  2 00000000 00000000 00 00000000 0

/* mem_subsystem.f */
+incdir+common
common/rv32i_types_pkg.sv
common/dmem_pkg.sv
memory_stage/pipe5_memory_stage.sv
dmem/dmem_lane.sv
src/dmem_extender.sv
src/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv
